// ==== include/space_params.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 640x480 timing, totals must fit a 10-bit coordinate
// SPR_SCALE must be a power of two
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SPACE_PARAMS_SVH
`define SPACE_PARAMS_SVH

// horizontal timing in pixels
`define H_RES    640
`define H_FP     16
`define H_SYNC   96
`define H_TOTAL  800

// vertical timing in lines
`define V_RES    480
`define V_FP     10
`define V_SYNC   2
`define V_TOTAL  525

`define SPR_SCALE 8               // 8x8 glyph shown as 64x64

// starfield layers, negative INC drifts left
`define SF1_SEED 21'h9A9A9
`define SF1_INC  (-1)
`define SF2_SEED 21'hA9A9A
`define SF2_INC  (-2)
`define SF3_SEED 21'h1FFFFF
`define SF3_INC  (-4)
`define SF3_MASK 21'h1FFC00       // fewer masked bits, denser far layer

`endif

// ==== verilog/display_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// unsigned coordinates only, syncs active low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package display_pkg;

    // screen position, covers totals up to 1023
    typedef logic [9:0] coord_t;

    // sync word as it leaves the chip
    typedef struct packed {
        logic hsync;              // low during horizontal sync
        logic vsync;              // low during vertical sync
        logic de;                 // high in the visible area
    } sync_t;

    // scan position plus the decoded syncs
    typedef struct packed {
        coord_t sx;
        coord_t sy;
        sync_t  sync;
    } scan_t;

endpackage

// ==== verilog/scene_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scene types and 8 fixed 8x8 glyphs, row 0 on top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package scene_pkg;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    typedef logic [7:0] glyph_row_t;   // msb is the leftmost pixel
    typedef logic [2:0] glyph_idx_t;
    typedef logic [7:0] star_t;        // star brightness, top nibble shown

    // sprite settings, one set per frame
    typedef struct packed {
        display_pkg::coord_t spr_x;
        display_pkg::coord_t spr_y;
        glyph_idx_t          glyph;
        rgb_t                spr_colour;
    } scene_cfg_t;

    // register map of the config port
    typedef enum logic [1:0] {
        REG_SPR_X  = 2'd0,
        REG_SPR_Y  = 2'd1,
        REG_GLYPH  = 2'd2,
        REG_COLOUR = 2'd3
    } cfg_reg_e;

    // [glyph][row]
    localparam glyph_row_t [0:7][0:7] glyph_table = '{
        '{8'h7E, 8'h60, 8'h60, 8'h7C, 8'h60, 8'h60, 8'h60, 8'h00},  // F
        '{8'h18, 8'h3C, 8'h66, 8'h66, 8'h7E, 8'h66, 8'h66, 8'h00},  // A
        '{8'h18, 8'h18, 8'h3C, 8'h7E, 8'hFF, 8'hDB, 8'h99, 8'h00},  // ship
        '{8'h3C, 8'h7E, 8'hDB, 8'hFF, 8'hFF, 8'h24, 8'h5A, 8'h81},  // alien
        '{8'h18, 8'h18, 8'hFF, 8'h3C, 8'h3C, 8'h66, 8'h42, 8'h00},  // star
        '{8'h66, 8'hFF, 8'hFF, 8'hFF, 8'h7E, 8'h3C, 8'h18, 8'h00},  // heart
        '{8'h18, 8'h3C, 8'h7E, 8'hFF, 8'h7E, 8'h3C, 8'h18, 8'h00},  // diamond
        '{8'h3C, 8'h42, 8'hA5, 8'h81, 8'hA5, 8'h99, 8'h42, 8'h3C}   // smiley
    };

endpackage

// ==== verilog/display_timing.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// syncs, de and strobes are decoded from the counters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "space_params.svh"

module display_timing (
    input  logic               clk_pix,
    input  logic               arst_n,
    output display_pkg::scan_t scan,
    output logic               line_strb,    // sx == H_RES, start of h blanking
    output logic               cfg_load      // first pixel of the last line
);
    import display_pkg::*;

    localparam coord_t H_LAST = coord_t'(`H_TOTAL - 1);
    localparam coord_t V_LAST = coord_t'(`V_TOTAL - 1);
    localparam coord_t HS_BEG = coord_t'(`H_RES + `H_FP);
    localparam coord_t HS_END = coord_t'(`H_RES + `H_FP + `H_SYNC);
    localparam coord_t VS_BEG = coord_t'(`V_RES + `V_FP);
    localparam coord_t VS_END = coord_t'(`V_RES + `V_FP + `V_SYNC);

    coord_t sx, sy;

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_LAST) begin   // end of line
            sx <= '0;
            sy <= (sy == V_LAST) ? '0 : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
    end

    always_comb begin
        scan.sx         = sx;
        scan.sy         = sy;
        scan.sync.hsync = ~(sx >= HS_BEG && sx < HS_END);  // active low
        scan.sync.vsync = ~(sy >= VS_BEG && sy < VS_END);
        scan.sync.de    = (sx < coord_t'(`H_RES)) && (sy < coord_t'(`V_RES));
        line_strb       = (sx == coord_t'(`H_RES));
        cfg_load        = (sx == '0) && (sy == V_LAST);
    end

endmodule

// ==== verilog/scene_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writes go to the shadow, active set moves at cfg_load
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "space_params.svh"

module scene_regs (
    input  logic                  clk_pix,
    input  logic                  arst_n,
    input  logic                  cfg_wr,      // one cycle strobe
    input  scene_pkg::cfg_reg_e   cfg_addr,
    input  logic [11:0]           cfg_data,
    input  logic                  cfg_load,
    output scene_pkg::scene_cfg_t active_cfg
);
    import display_pkg::*;
    import scene_pkg::*;

    // sprite parked just past the visible area
    localparam scene_cfg_t CFG_RESET = '{
        spr_x: coord_t'(`H_RES), spr_y: coord_t'(`V_RES), glyph: '0, spr_colour: '0};

    scene_cfg_t shadow;

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            shadow     <= CFG_RESET;
            active_cfg <= CFG_RESET;
        end else begin
            if (cfg_load) active_cfg <= shadow;   // old shadow, same-cycle write waits
            if (cfg_wr) begin
                case (cfg_addr)
                    REG_SPR_X:  shadow.spr_x      <= cfg_data[9:0];
                    REG_SPR_Y:  shadow.spr_y      <= cfg_data[9:0];
                    REG_GLYPH:  shadow.glyph      <= cfg_data[2:0];
                    REG_COLOUR: shadow.spr_colour <= rgb_t'(cfg_data);  // 12'hRGB
                endcase
            end
        end
    end

endmodule

// ==== verilog/glyph_sprite.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// row for line n+1 is fetched at line_strb of line n
// window may run past the visible area, mixer blanks it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "space_params.svh"

module glyph_sprite (
    input  logic                  clk_pix,
    input  logic                  arst_n,
    input  display_pkg::scan_t    scan,
    input  logic                  line_strb,
    input  scene_pkg::scene_cfg_t active_cfg,
    output logic                  spr_pix
);
    import display_pkg::*;
    import scene_pkg::*;

    localparam int          SH     = $clog2(`SPR_SCALE);  // scale as shift
    localparam logic [10:0] SPAN   = 11'(8 * `SPR_SCALE); // window size in pixels
    localparam coord_t      V_LAST = coord_t'(`V_TOTAL - 1);

    coord_t      ny;          // line being prepared
    logic [10:0] dy, dx;      // offsets into the window
    glyph_row_t  row_q;       // glyph line for the current scan line

    // 11-bit difference, a negative offset wraps above SPAN
    // so one compare covers both window edges
    always_comb begin
        ny = (scan.sy == V_LAST) ? '0 : scan.sy + 1'b1;
        dy = {1'b0, ny} - {1'b0, active_cfg.spr_y};
        dx = {1'b0, scan.sx} - {1'b0, active_cfg.spr_x};
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            row_q <= '0;
        end else if (line_strb) begin
            if (dy < SPAN)
                row_q <= glyph_table[active_cfg.glyph][dy[SH+2:SH]];
            else
                row_q <= '0;      // line outside the sprite
        end
    end

    // inverting the column gives 7-col, msb is leftmost
    always_comb begin
        if (dx < SPAN)
            spr_pix = row_q[~dx[SH+2:SH]];
        else
            spr_pix = 1'b0;
    end

endmodule

// ==== verilog/starfield.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// free running, period is one frame plus INC cycles
// MASK must leave bits 7:0 free so brightness varies
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "space_params.svh"

module starfield #(
    parameter int          INC  = -1,          // drift per frame in pixels
    parameter logic [20:0] SEED = 21'h1FFFFF,  // must be non-zero
    parameter logic [20:0] MASK = 21'h1FFE00   // more bits, fewer stars
) (
    input  logic             clk_pix,
    input  logic             arst_n,
    output logic             sf_on,
    output scene_pkg::star_t star
);
    localparam logic [20:0]      TAPS   = 21'h140000;  // taps 21 and 19
    localparam int               PERIOD = `H_TOTAL * `V_TOTAL;
    localparam int               CNT_W  = $clog2(PERIOD);
    localparam logic [CNT_W-1:0] LAST   = CNT_W'(PERIOD + INC - 1);

    logic [20:0]      sreg;   // galois lfsr, shifts right
    logic [CNT_W-1:0] cnt;    // steps since last reseed

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sreg <= SEED;
            cnt  <= '0;
        end else if (cnt == LAST) begin   // short period, stars shift by INC
            sreg <= SEED;
            cnt  <= '0;
        end else begin
            sreg <= sreg[0] ? (sreg >> 1) ^ TAPS : sreg >> 1;
            cnt  <= cnt + 1'b1;
        end
    end

    assign sf_on = &(sreg | ~MASK);   // all masked bits set
    assign star  = sreg[7:0];

endmodule

// ==== verilog/pixel_mixer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// outputs lag the scan by one cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pixel_mixer (
    input  logic                  clk_pix,
    input  logic                  arst_n,
    input  display_pkg::scan_t    scan,
    input  logic                  spr_pix,
    input  scene_pkg::scene_cfg_t active_cfg,
    input  logic [2:0]            sf_on,     // bit 0 is sf1, the nearest layer
    input  scene_pkg::star_t      star1,
    input  scene_pkg::star_t      star2,
    input  scene_pkg::star_t      star3,
    output display_pkg::sync_t    video,
    output scene_pkg::rgb_t       colour
);
    import scene_pkg::*;

    logic [3:0] starlight;    // grey level of the top star layer
    rgb_t       pix;

    always_comb begin
        if (sf_on[0])      starlight = star1[7:4];
        else if (sf_on[1]) starlight = star2[7:4];
        else if (sf_on[2]) starlight = star3[7:4];
        else               starlight = 4'h0;   // empty sky
        // sprite covers the stars
        pix = spr_pix ? active_cfg.spr_colour :
                        '{red: starlight, green: starlight, blue: starlight};
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            video  <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};  // syncs idle high
            colour <= '0;
        end else begin
            video  <= scan.sync;
            colour <= scan.sync.de ? pix : '0;    // black in blanking
        end
    end

endmodule

// ==== verilog/space_f_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clk_pix is the 640x480 pixel clock, no pll inside
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "space_params.svh"

module space_f_top (
    input  logic                clk_pix,
    input  logic                arst_n,
    input  logic                cfg_wr,
    input  scene_pkg::cfg_reg_e cfg_addr,
    input  logic [11:0]         cfg_data,
    output display_pkg::sync_t  video,
    output scene_pkg::rgb_t     colour
);
    import display_pkg::*;
    import scene_pkg::*;

    scan_t      scan;
    logic       line_strb, cfg_load;
    scene_cfg_t active_cfg;
    logic       spr_pix;
    logic [2:0] sf_on;                  // {sf3, sf2, sf1}
    star_t      star1, star2, star3;

    display_timing u_display_timing (.clk_pix, .arst_n, .scan, .line_strb, .cfg_load);

    scene_regs u_scene_regs (
        .clk_pix, .arst_n, .cfg_wr, .cfg_addr, .cfg_data, .cfg_load, .active_cfg);

    glyph_sprite u_glyph_sprite (.clk_pix, .arst_n, .scan, .line_strb, .active_cfg, .spr_pix);

    // near to far, sf1 and sf2 keep the default mask
    starfield #(.INC(`SF1_INC), .SEED(`SF1_SEED)) sf1 (
        .clk_pix, .arst_n, .sf_on(sf_on[0]), .star(star1));
    starfield #(.INC(`SF2_INC), .SEED(`SF2_SEED)) sf2 (
        .clk_pix, .arst_n, .sf_on(sf_on[1]), .star(star2));
    starfield #(.INC(`SF3_INC), .SEED(`SF3_SEED), .MASK(`SF3_MASK)) sf3 (
        .clk_pix, .arst_n, .sf_on(sf_on[2]), .star(star3));

    pixel_mixer u_pixel_mixer (
        .clk_pix, .arst_n, .scan, .spr_pix, .active_cfg, .sf_on,
        .star1, .star2, .star3, .video, .colour);

endmodule

// ==== verif/tb_space_f.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 5 frames of random config writes, model checked every pixel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "space_params.svh"

module tb_space_f;
    import display_pkg::*;
    import scene_pkg::*;

    localparam int CLK_NS       = 4;
    localparam int FRAMES       = 5;
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int WATCHDOG_NS  = FRAMES * FRAME_CYCLES * CLK_NS * 11 / 10;  // 10% margin
    localparam int HS_BEG       = `H_RES + `H_FP;
    localparam int HS_END       = `H_RES + `H_FP + `H_SYNC;
    localparam int VS_BEG       = `V_RES + `V_FP;
    localparam int VS_END       = `V_RES + `V_FP + `V_SYNC;
    localparam int SPAN         = 8 * `SPR_SCALE;                // sprite window width
    localparam logic [20:0] TAPS      = (21'd1 << 20) | (21'd1 << 18);  // taps 21, 19
    localparam logic [20:0] SEEDS [3] = '{`SF1_SEED, `SF2_SEED, `SF3_SEED};
    localparam logic [20:0] MASKS [3] = '{21'h1FFE00, 21'h1FFE00, `SF3_MASK}; // near layers sparse
    localparam int          INCS  [3] = '{`SF1_INC, `SF2_INC, `SF3_INC};

    logic        clk_pix, arst_n, cfg_wr, check_en;
    cfg_reg_e    cfg_addr;
    logic [11:0] cfg_data;
    sync_t       video;
    rgb_t        colour;

    // model state
    int          m_sx, m_sy, frames, fails;
    scene_cfg_t  m_shadow, m_active;
    glyph_row_t  m_row;
    logic [20:0] m_lfsr [3];
    int          m_cnt [3];
    sync_t       exp_video;
    rgb_t        exp_colour;
    logic [31:0] lcg_state = 32'd28555;

    space_f_top u_space_f_top (
        .clk_pix, .arst_n, .cfg_wr, .cfg_addr, .cfg_data, .video, .colour);

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic reset_model();
        m_sx     = 0;
        m_sy     = 0;
        m_shadow = '{spr_x: 10'(`H_RES), spr_y: 10'(`V_RES), glyph: '0, spr_colour: '0};
        m_active = m_shadow;   // sprite parked off-screen
        m_row    = '0;
        for (int k = 0; k < 3; k++) begin
            m_lfsr[k] = SEEDS[k];
            m_cnt[k]  = 0;
        end
        exp_video  = '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};
        exp_colour = '0;
    endtask

    // one pixel clock, every update from the state before the edge
    task automatic step_model();
        sync_t      nsync;
        logic       spr, line_strb, cfg_load;
        logic [3:0] grey;
        int         ny, dx, dy;
        nsync.hsync = !(m_sx >= HS_BEG && m_sx < HS_END);
        nsync.vsync = !(m_sy >= VS_BEG && m_sy < VS_END);
        nsync.de    = (m_sx < `H_RES) && (m_sy < `V_RES);
        line_strb   = (m_sx == `H_RES);
        cfg_load    = (m_sx == 0) && (m_sy == `V_TOTAL - 1);
        dx  = m_sx - int'(m_active.spr_x);
        spr = (dx >= 0 && dx < SPAN) ? m_row[7 - dx / `SPR_SCALE] : 1'b0;  // msb leftmost
        grey = 4'h0;
        for (int k = 2; k >= 0; k--) begin   // far to near, nearest wins
            if ((m_lfsr[k] & MASKS[k]) == MASKS[k])
                grey = m_lfsr[k][7:4];
        end
        exp_video = nsync;
        if (!nsync.de)
            exp_colour = '0;
        else if (spr)
            exp_colour = m_active.spr_colour;
        else
            exp_colour = {grey, grey, grey};
        if (line_strb) begin   // prepare the next line's glyph row
            ny = (m_sy == `V_TOTAL - 1) ? 0 : m_sy + 1;
            dy = ny - int'(m_active.spr_y);
            m_row = (dy >= 0 && dy < SPAN) ?
                    glyph_table[m_active.glyph][dy / `SPR_SCALE] : '0;
        end
        if (cfg_load)
            m_active = m_shadow;   // old shadow, write below waits a frame
        if (cfg_wr) begin
            case (cfg_addr)
                REG_SPR_X:  m_shadow.spr_x      = cfg_data[9:0];
                REG_SPR_Y:  m_shadow.spr_y      = cfg_data[9:0];
                REG_GLYPH:  m_shadow.glyph      = cfg_data[2:0];
                REG_COLOUR: m_shadow.spr_colour = rgb_t'(cfg_data);
            endcase
        end
        for (int k = 0; k < 3; k++) begin
            if (m_cnt[k] == FRAME_CYCLES + INCS[k] - 1) begin   // shortened frame
                m_lfsr[k] = SEEDS[k];
                m_cnt[k]  = 0;
            end else begin
                m_lfsr[k] = m_lfsr[k][0] ? (m_lfsr[k] >> 1) ^ TAPS : m_lfsr[k] >> 1;
                m_cnt[k]++;
            end
        end
        if (m_sx == `H_TOTAL - 1) begin
            m_sx = 0;
            if (m_sy == `V_TOTAL - 1) begin
                m_sy = 0;
                frames++;
            end else begin
                m_sy++;
            end
        end else begin
            m_sx++;
        end
    endtask

    // model now holds the scan the DUT sees at the next edge
    task automatic drive_stimulus();
        logic [31:0] r, pick;
        r = lcg_next();
        if (m_sx == 0 && m_sy == `V_TOTAL - 1 && frames >= 1 && frames <= 3) begin
            cfg_wr   <= 1'b1;                          // coincides with cfg_load
            cfg_addr <= cfg_reg_e'(2'(frames - 1));    // x, then y, then glyph
            cfg_data <= (frames == 3) ? 12'd3 : 12'd200;
        end else if ((r >> 8) % 20000 == 0) begin
            pick = lcg_next();
            cfg_wr   <= 1'b1;
            cfg_addr <= cfg_reg_e'(pick[1:0]);
            case (cfg_reg_e'(pick[1:0]))
                REG_SPR_X: cfg_data <= 12'((pick >> 8) % 700);  // some past the edge
                REG_SPR_Y: cfg_data <= 12'((pick >> 8) % 520);
                default:   cfg_data <= pick[31:20];
            endcase
        end
    endtask

    initial begin
        clk_pix = 1'b0;
        forever #(CLK_NS / 2) clk_pix = ~clk_pix;
    end

    always @(posedge clk_pix) begin
        cfg_wr <= 1'b0;
        if (!arst_n)
            reset_model();
        else if (check_en) begin
            step_model();
            drive_stimulus();
        end
    end

    always @(negedge clk_pix) begin
        if (check_en) begin
            assert (video === exp_video && colour === exp_colour)
            else begin
                fails++;
                $display("Error at %0t: expected video %b colour %h, got video %b colour %h",
                         $time, exp_video, exp_colour, video, colour);
                $display("Verification failed");
                $fatal(1, "stopped at first mismatch");
            end
        end
    end

    initial begin
        arst_n   = 1'b1;      // high first so the reset sees a falling edge
        check_en = 1'b0;
        cfg_wr   = 1'b0;
        cfg_addr = REG_SPR_X;
        cfg_data = '0;
        frames   = 0;
        fails    = 0;
        reset_model();
        @(posedge clk_pix);
        arst_n   <= 1'b0;
        check_en <= 1'b1;
        repeat (8) @(posedge clk_pix);
        arst_n <= 1'b1;
        while (frames < FRAMES) @(negedge clk_pix);
        @(posedge clk_pix);   // let the last pixel check run
        if (fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Simulation timed out after %0d ns before %0d frames completed",
                 WATCHDOG_NS, FRAMES);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== space_f.f ====
+incdir+include
verilog/display_pkg.sv
verilog/scene_pkg.sv
verilog/display_timing.sv
verilog/scene_regs.sv
verilog/glyph_sprite.sv
verilog/starfield.sv
verilog/pixel_mixer.sv
verilog/space_f_top.sv
verif/tb_space_f.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds tb_space_f with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f space_f.f --top-module tb_space_f -o tb_space_f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_space_f > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
